/* source/fetch_pkg.sv */
// Shared widths, FIFO sizing and RV32 field layouts for the fetch front end
// FIFO_DEPTH must be a power of two and also caps the outstanding fetches
package fetch_pkg;

  localparam int ADDR_W  = 32;
  localparam int INSTR_W = 32;

  // One FIFO slot per outstanding fetch
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  // Wide enough to hold FIFO_DEPTH itself
  localparam int CNT_W      = 3;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  // Register-immediate layout
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // Same 32 bits seen through both formats
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_word_t;

endpackage

/* source/fetch_ifs.sv */
// Links inside the fetch front end
// A push is a single-cycle strobe and is never refused by the FIFO
`timescale 1ns/1ps

// Prefetcher to FIFO, space counts free entries
interface fetch_push_if
  import fetch_pkg::*;
();

  logic               push;
  logic [INSTR_W-1:0] word;
  logic [ADDR_W-1:0]  pc;
  logic               err;
  logic [CNT_W-1:0]   space;

  modport src (
    output push, word, pc, err,
    input  space
  );

  modport dst (
    input  push, word, pc, err,
    output space
  );

endinterface

// FIFO to predecoder, pop is a strobe raised only while valid is high
interface fetch_pop_if
  import fetch_pkg::*;
();

  logic               valid;
  logic [INSTR_W-1:0] word;
  logic [ADDR_W-1:0]  pc;
  logic               err;
  logic               pop;
  // FIFO is being cleared this cycle
  logic               flush;

  modport src (
    output valid, word, pc, err, flush,
    input  pop
  );

  modport dst (
    input  valid, word, pc, err, flush,
    output pop
  );

endinterface

/* source/prefetcher.sv */
// Instruction bus master with req/gnt address phase and in-order rvalid responses
// Never has more fetches in flight than the FIFO has free slots
// A branch discards every in-flight response, including one still waiting for grant
`timescale 1ns/1ps

module prefetcher
  import fetch_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic [ADDR_W-1:0]  boot_addr_i,
  input  logic               branch_i,
  input  logic [ADDR_W-1:0]  branch_addr_i,
  output logic               instr_req_o,
  output logic [ADDR_W-1:0]  instr_addr_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  logic [INSTR_W-1:0] instr_rdata_i,
  input  logic               instr_err_i,
  fetch_push_if.src          push
);

  logic              started_q;
  logic              branch_pend_q;
  logic              branch_pend_d;
  logic [ADDR_W-1:0] target_q;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] addr_d;
  logic [ADDR_W-1:0] fetch_addr;
  logic [ADDR_W-1:0] rsp_pc_q;
  logic [ADDR_W-1:0] rsp_pc_d;
  logic [ADDR_W-1:0] rsp_pc;
  logic [CNT_W-1:0]  outst_q;
  logic [CNT_W-1:0]  outst_d;
  logic [CNT_W-1:0]  discard_q;
  logic [CNT_W-1:0]  discard_d;
  logic              grant;
  logic              stale;

  // Boot address is used until the first clock edge after reset
  assign fetch_addr = started_q ? addr_q : boot_addr_i;
  assign rsp_pc     = started_q ? rsp_pc_q : boot_addr_i;

  // Room must exist for every response already in flight
  assign instr_req_o  = started_q && (push.space > outst_q);
  assign instr_addr_o = fetch_addr;

  assign grant = instr_req_o && instr_gnt_i;
  assign stale = branch_i || (discard_q != '0);

  assign push.push = instr_rvalid_i && !stale;
  assign push.word = instr_rdata_i;
  assign push.pc   = rsp_pc;
  assign push.err  = instr_err_i;

  always_comb begin
    outst_d       = outst_q + CNT_W'(grant) - CNT_W'(instr_rvalid_i);
    addr_d        = fetch_addr;
    branch_pend_d = branch_pend_q;

    if (branch_i) begin
      if (instr_req_o && !instr_gnt_i) begin
        // Open request stays put, redirect once it is granted
        branch_pend_d = 1'b1;
      end else begin
        addr_d        = branch_addr_i;
        branch_pend_d = 1'b0;
      end
    end else if (grant) begin
      addr_d        = branch_pend_q ? target_q : fetch_addr + ADDR_W'(4);
      branch_pend_d = 1'b0;
    end

    if (branch_i) begin
      // Everything granted so far, this cycle included, is now stale
      discard_d = outst_d;
    end else begin
      discard_d = discard_q;
      if (instr_rvalid_i && (discard_q != '0)) begin
        discard_d = discard_d - CNT_W'(1);
      end
      // Held request from before the branch got its grant
      if (branch_pend_q && grant) begin
        discard_d = discard_d + CNT_W'(1);
      end
    end

    if (branch_i) begin
      rsp_pc_d = branch_addr_i;
    end else if (push.push) begin
      rsp_pc_d = rsp_pc + ADDR_W'(4);
    end else begin
      rsp_pc_d = rsp_pc;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      started_q     <= 1'b0;
      branch_pend_q <= 1'b0;
      outst_q       <= '0;
      discard_q     <= '0;
    end else begin
      started_q     <= 1'b1;
      branch_pend_q <= branch_pend_d;
      outst_q       <= outst_d;
      discard_q     <= discard_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q   <= addr_d;
    rsp_pc_q <= rsp_pc_d;
    if (branch_i) begin
      target_q <= branch_addr_i;
    end
  end

endmodule

/* source/fetch_fifo.sv */
// Circular buffer of fetched words with their pc and bus error flag
// Write data is visible on the read side one cycle after the push
// flush_i empties the buffer and wins over a push or pop in the same cycle
`timescale 1ns/1ps

module fetch_fifo
  import fetch_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      flush_i,
  fetch_push_if.dst push,
  fetch_pop_if.src  pop
);

  logic [INSTR_W-1:0] word_mem [FIFO_DEPTH];
  logic [ADDR_W-1:0]  pc_mem   [FIFO_DEPTH];
  logic               err_mem  [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_pop;

  assign pop.valid  = (count_q != '0);
  assign pop.word   = word_mem[rd_ptr_q];
  assign pop.pc     = pc_mem[rd_ptr_q];
  assign pop.err    = err_mem[rd_ptr_q];
  assign pop.flush  = flush_i;

  assign push.space = CNT_W'(FIFO_DEPTH) - count_q;

  // Guard against a pop strobe on an empty buffer
  assign do_pop = pop.pop && pop.valid;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push.push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      count_q <= count_q + CNT_W'(push.push) - CNT_W'(do_pop);
    end
  end

  // Storage, pointers alone decide what is valid
  always_ff @(posedge clk_i) begin
    if (push.push) begin
      word_mem[wr_ptr_q] <= push.word;
      pc_mem[wr_ptr_q]   <= push.pc;
      err_mem[wr_ptr_q]  <= push.err;
    end
  end

endmodule

/* source/instr_predecoder.sv */
// Single output register toward decode with a valid/ready level pair
// All id_ outputs hold while id_valid_o is high and id_ready_i is low
// Only OP and OP-IMM are recognised; any other opcode is flagged illegal
`timescale 1ns/1ps

module instr_predecoder
  import fetch_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               flush_i,
  input  logic               id_ready_i,
  fetch_pop_if.dst           pop,
  output logic               id_valid_o,
  output logic [ADDR_W-1:0]  id_pc_o,
  output logic [INSTR_W-1:0] id_instr_o,
  output logic [4:0]         id_rd_o,
  output logic [4:0]         id_rs1_o,
  output logic [4:0]         id_rs2_o,
  output logic [INSTR_W-1:0] id_imm_o,
  output logic               id_is_reg_o,
  output logic               id_illegal_o,
  output logic               id_err_o
);

  logic              valid_q;
  logic [ADDR_W-1:0] pc_q;
  instr_word_t       instr_q;
  logic              err_q;
  logic              load;
  logic              known_opc;

  // Refill when empty or when decode takes the current one
  // FIFO contents are void during its clear
  assign load    = pop.valid && !pop.flush && (!valid_q || id_ready_i);
  assign pop.pop = load;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      pc_q    <= pop.pc;
      instr_q <= pop.word;
      err_q   <= pop.err;
    end
  end

  assign known_opc = (instr_q.r.opcode == OPC_OP) || (instr_q.r.opcode == OPC_OP_IMM);

  assign id_valid_o   = valid_q;
  assign id_pc_o      = pc_q;
  assign id_instr_o   = instr_q;
  assign id_err_o     = err_q;
  assign id_rd_o      = instr_q.r.rd;
  assign id_rs1_o     = instr_q.r.rs1;
  // rs2 only means something in the R view, imm only in the I view
  assign id_rs2_o     = instr_q.r.rs2;
  assign id_imm_o     = {{(INSTR_W - 12){instr_q.i.imm12[11]}}, instr_q.i.imm12};
  assign id_is_reg_o  = (instr_q.r.opcode == OPC_OP);
  assign id_illegal_o = err_q || !known_opc;

endmodule

/* source/fetch_stage.sv */
// Fetch front end: prefetcher, fetch FIFO and predecoder
// boot_addr_i must be stable around reset release
// branch_i is a one-cycle pulse, branch_addr_i must be word aligned
`timescale 1ns/1ps

module fetch_stage
  import fetch_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,

  // Fetch control
  input  logic [ADDR_W-1:0]  boot_addr_i,
  input  logic               branch_i,
  input  logic [ADDR_W-1:0]  branch_addr_i,

  // Instruction bus
  output logic               instr_req_o,
  output logic [ADDR_W-1:0]  instr_addr_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  logic [INSTR_W-1:0] instr_rdata_i,
  input  logic               instr_err_i,

  // Toward decode
  output logic               id_valid_o,
  output logic [ADDR_W-1:0]  id_pc_o,
  output logic [INSTR_W-1:0] id_instr_o,
  output logic [4:0]         id_rd_o,
  output logic [4:0]         id_rs1_o,
  output logic [4:0]         id_rs2_o,
  output logic [INSTR_W-1:0] id_imm_o,
  output logic               id_is_reg_o,
  output logic               id_illegal_o,
  output logic               id_err_o,
  input  logic               id_ready_i
);

  fetch_push_if push_if ();
  fetch_pop_if  pop_if ();

  prefetcher prefetcher_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .boot_addr_i    (boot_addr_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .push           (push_if.src)
  );

  // A branch clears both storage stages in the same cycle
  fetch_fifo fetch_fifo_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (branch_i),
    .push     (push_if.dst),
    .pop      (pop_if.src)
  );

  instr_predecoder instr_predecoder_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flush_i      (branch_i),
    .id_ready_i   (id_ready_i),
    .pop          (pop_if.dst),
    .id_valid_o   (id_valid_o),
    .id_pc_o      (id_pc_o),
    .id_instr_o   (id_instr_o),
    .id_rd_o      (id_rd_o),
    .id_rs1_o     (id_rs1_o),
    .id_rs2_o     (id_rs2_o),
    .id_imm_o     (id_imm_o),
    .id_is_reg_o  (id_is_reg_o),
    .id_illegal_o (id_illegal_o),
    .id_err_o     (id_err_o)
  );

endmodule

/* verif/obi_mem_responder.sv */
// Testbench instruction memory that answers every grant once and in order
// Word at an address is its own xorshift, with err set when addr[7:2] is all ones
// Outputs change on the falling edge; grant and response delays are random
`timescale 1ns/1ps

module obi_mem_responder (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  logic [31:0] delay_state = 32'd20;
  logic [31:0] pending [$];

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Bus lines idle before the first falling edge
  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
  end

  always @(negedge clk_i) begin
    logic [31:0] addr;
    // Unknown reset level at time zero counts as reset
    if (arst_n_i !== 1'b1) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      pending.delete();
    end else begin
      delay_state = xorshift(delay_state);
      // Answering before granting keeps each response a cycle or more behind its grant
      if ((pending.size() > 0) && (delay_state[1:0] != 2'b00)) begin
        addr = pending.pop_front();
        rvalid_o <= 1'b1;
        rdata_o  <= xorshift(addr);
        err_o    <= &addr[7:2];
      end else begin
        rvalid_o <= 1'b0;
      end
      if (req_i && (delay_state[4:3] != 2'b00)) begin
        gnt_o <= 1'b1;
        pending.push_back(addr_i);
      end else begin
        gnt_o <= 1'b0;
      end
    end
  end

endmodule

/* verif/tb_fetch_stage.sv */
// Testbench for the fetch front end with a random-delay instruction memory
// Inputs change and outputs are sampled on the falling edge
// Decode never accepts in the cycle that a branch is raised
`timescale 1ns/1ps

module tb_fetch_stage
  import fetch_pkg::*;
();

  localparam logic [31:0] SEED         = 32'd20;
  localparam logic [31:0] BOOT_ADDR    = 32'h0000_1F00;
  localparam int          RESET_CYCLES = 5;
  localparam int          WAIT_LIMIT   = 200;
  localparam int          FIRST_COUNT  = 80;
  localparam int          TOTAL_COUNT  = 400;

  logic               clk_i;
  logic               arst_n_i;
  logic [ADDR_W-1:0]  boot_addr_i;
  logic               branch_i;
  logic [ADDR_W-1:0]  branch_addr_i;
  logic               instr_req_o;
  logic [ADDR_W-1:0]  instr_addr_o;
  logic               instr_gnt_i;
  logic               instr_rvalid_i;
  logic [INSTR_W-1:0] instr_rdata_i;
  logic               instr_err_i;
  logic               id_valid_o;
  logic [ADDR_W-1:0]  id_pc_o;
  logic [INSTR_W-1:0] id_instr_o;
  logic [4:0]         id_rd_o;
  logic [4:0]         id_rs1_o;
  logic [4:0]         id_rs2_o;
  logic [INSTR_W-1:0] id_imm_o;
  logic               id_is_reg_o;
  logic               id_illegal_o;
  logic               id_err_o;
  logic               id_ready_i;

  // Reference model state
  logic [31:0]       rng_state;
  logic [ADDR_W-1:0] expect_pc;
  int                n_acc;
  int                n_branch;
  int                n_err;

  // Snapshots from the previous falling edge
  logic              prev_req;
  logic [ADDR_W-1:0] prev_addr;
  logic              prev_stall;
  logic              prev_branch;
  logic [ADDR_W-1:0] prev_pc;
  logic [31:0]       prev_instr;
  logic [49:0]       prev_fields;

  fetch_stage fetch_stage_i (.*);

  obi_mem_responder obi_mem_responder_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i),
    .err_o    (instr_err_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [49:0] id_fields();
    return {id_rd_o, id_rs1_o, id_rs2_o, id_imm_o, id_is_reg_o, id_illegal_o, id_err_o};
  endfunction

  task automatic stop_run();
    $display("Something failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      $display("FAILED %s: expected %0h, actual %0h", name, exp_val, act_val);
      stop_run();
    end
  endtask

  // Compare the instruction decode is taking against the memory word at expect_pc
  task automatic check_accept();
    logic [31:0] word;
    logic        err;
    logic [6:0]  opc;
    word = xorshift(expect_pc);
    err  = &expect_pc[7:2];
    opc  = word[6:0];
    check_value("accept pc", expect_pc, id_pc_o);
    check_value("accept instr", word, id_instr_o);
    check_value("accept err", err, id_err_o);
    check_value("accept rd", word[11:7], id_rd_o);
    check_value("accept rs1", word[19:15], id_rs1_o);
    check_value("accept rs2", word[24:20], id_rs2_o);
    check_value("accept imm", {{20{word[31]}}, word[31:20]}, id_imm_o);
    check_value("accept is_reg", opc == OPC_OP, id_is_reg_o);
    check_value("accept illegal", err || !((opc == OPC_OP) || (opc == OPC_OP_IMM)),
                id_illegal_o);
    if (err) begin
      n_err++;
    end
  endtask

  task automatic step_cycle(input bit rand_ready, input bit allow_branch);
    logic              next_ready;
    logic              do_branch;
    logic [ADDR_W-1:0] target;
    @(negedge clk_i);
    // Open request must not move until granted
    if (prev_req && !instr_gnt_i) begin
      check_value("bus req held", 1, instr_req_o);
      check_value("bus addr held", prev_addr, instr_addr_o);
    end
    if (prev_stall && !prev_branch) begin
      check_value("hold valid", 1, id_valid_o);
      check_value("hold pc", prev_pc, id_pc_o);
      check_value("hold instr", prev_instr, id_instr_o);
      check_value("hold fields", prev_fields, id_fields());
    end
    rng_state  = xorshift(rng_state);
    do_branch  = allow_branch && (rng_state[5:0] == 6'd0);
    next_ready = do_branch ? 1'b0 : (rand_ready ? rng_state[8] : 1'b1);
    target     = 32'h0000_2000 + {rng_state[19:10], 2'b00};
    if (id_valid_o && next_ready) begin
      check_accept();
      expect_pc = expect_pc + 4;
      n_acc++;
    end
    if (do_branch) begin
      expect_pc = target;
      n_branch++;
      branch_addr_i <= target;
    end
    branch_i    <= do_branch;
    id_ready_i  <= next_ready;
    prev_req    = instr_req_o;
    prev_addr   = instr_addr_o;
    prev_stall  = id_valid_o && !next_ready;
    prev_branch = do_branch;
    prev_pc     = id_pc_o;
    prev_instr  = id_instr_o;
    prev_fields = id_fields();
  endtask

  task automatic run_until(input int target, input bit rand_ready, input bit allow_branch);
    int idle;
    int last;
    idle = 0;
    while (n_acc < target) begin
      last = n_acc;
      step_cycle(rand_ready, allow_branch);
      idle = (n_acc == last) ? idle + 1 : 0;
      if (idle > WAIT_LIMIT) begin
        $display("Timeout: no instruction accepted for %0d cycles", WAIT_LIMIT);
        stop_run();
      end
    end
  endtask

  initial begin
    arst_n_i      = 1'b0;
    boot_addr_i   = BOOT_ADDR;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    id_ready_i    = 1'b0;
    rng_state     = SEED;
    expect_pc     = BOOT_ADDR;
    n_acc         = 0;
    n_branch      = 0;
    n_err         = 0;
    prev_stall    = 1'b0;
    prev_branch   = 1'b0;

    // Reset spans five rising edges and is released on the next falling edge
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    check_value("reset req", 0, instr_req_o);
    check_value("reset valid", 0, id_valid_o);
    arst_n_i   <= 1'b1;
    id_ready_i <= 1'b1;
    @(negedge clk_i);
    check_value("boot req", 1, instr_req_o);
    check_value("boot addr", BOOT_ADDR, instr_addr_o);
    prev_req  = instr_req_o;
    prev_addr = instr_addr_o;

    // Straight-line fetch with decode always ready before back-pressure and branches
    run_until(FIRST_COUNT, 1'b0, 1'b0);
    run_until(TOTAL_COUNT, 1'b1, 1'b1);
    check_value("branches taken", 1, n_branch != 0);
    check_value("error words seen", 1, n_err != 0);

    $display("Everything OK");
    $finish;
  end

endmodule

/* vlog.f */
source/fetch_pkg.sv
source/fetch_ifs.sv
source/prefetcher.sv
source/fetch_fifo.sv
source/instr_predecoder.sv
source/fetch_stage.sv
verif/obi_mem_responder.sv
verif/tb_fetch_stage.sv
